/* tb.f */
+incdir+.
dma_pkg.sv
dma_ctrl.sv
dma_block_reader.sv
dma_block_buf.sv
dma_block_writer.sv
wb_dma.sv
tb_wb_dma.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_wb_dma
LOG ?= sim.log
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir

FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP LOG FILELIST OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --timescale 1ns/1ps -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_wb_dma.sv */
// DMA engine testbench
`timescale 1ns/1ps
`include "dma_params.svh"

module tb_wb_dma;

	// about a dozen short transfers of at most 40 words, each word read and written once at
	// up to four cycles per access, plus register traffic and the abort run cut short
	// after a few dozen cycles, stays far below this
	localparam int MAX_CYCLES = 20000;

	logic i_clk = 1'b0;
	logic i_reset;
	logic i_swb_cyc;
	logic i_swb_stb;
	logic i_swb_we;
	logic [1:0] i_swb_addr;
	logic [31:0] i_swb_data;
	logic o_swb_ack;
	logic o_swb_stall;
	logic [31:0] o_swb_data;
	logic o_mwb_cyc;
	logic o_mwb_stb;
	logic o_mwb_we;
	logic [`DMA_AW-1:0] o_mwb_addr;
	logic [31:0] o_mwb_data;
	logic i_mwb_ack = 1'b0;
	logic i_mwb_stall = 1'b0;
	logic i_mwb_err = 1'b0;
	logic [31:0] i_mwb_data = 32'd0;
	logic o_interrupt;

	int seed = 32'h85b9;
	int bus_seed = 32'h85b9 ^ 32'h3c3c;
	int cycle = 0;
	int irq_count = 0;

	// memory behind the master port and the copy the checks expect
	logic [31:0] mem [0:255];
	logic [31:0] ref_mem [0:255];
	logic fill_req = 1'b0;
	logic [31:0] fill_key = 32'd0;
	logic err_en = 1'b0;
	logic [`DMA_AW-1:0] err_addr = '0;

	// responses still owed by the slave, oldest first
	int q_due[$];
	logic [31:0] q_data[$];
	bit q_err[$];
	int last_due = 0;

	wb_dma u_wb_dma (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_swb_cyc(i_swb_cyc),
		.i_swb_stb(i_swb_stb),
		.i_swb_we(i_swb_we),
		.i_swb_addr(i_swb_addr),
		.i_swb_data(i_swb_data),
		.o_swb_ack(o_swb_ack),
		.o_swb_stall(o_swb_stall),
		.o_swb_data(o_swb_data),
		.o_mwb_cyc(o_mwb_cyc),
		.o_mwb_stb(o_mwb_stb),
		.o_mwb_we(o_mwb_we),
		.o_mwb_addr(o_mwb_addr),
		.o_mwb_data(o_mwb_data),
		.i_mwb_ack(i_mwb_ack),
		.i_mwb_stall(i_mwb_stall),
		.i_mwb_err(i_mwb_err),
		.i_mwb_data(i_mwb_data),
		.o_interrupt(o_interrupt)
	);

	always #10 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// every bit of the word address shows up in the fill value
	function automatic logic [31:0] pattern_word(input logic [7:0] a, input logic [31:0] key);
		return {a, ~a, a ^ key[7:0], ~a} ^ key;
	endfunction

	function automatic int random_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// control word that starts a transfer
	function automatic logic [31:0] ctrl_word(input logic inc_s_n, input logic inc_d_n,
		input logic [9:0] blk);
		return {2'b00, inc_s_n, inc_d_n, `DMA_UNLOCK_KEY, 6'd0, blk};
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
	endtask

	// one slave access, the ack comes the cycle after the strobe is taken
	task automatic wb_write(input logic [1:0] addr, input logic [31:0] data);
		@(posedge i_clk);
		i_swb_cyc <= 1'b1;
		i_swb_stb <= 1'b1;
		i_swb_we <= 1'b1;
		i_swb_addr <= addr;
		i_swb_data <= data;
		@(posedge i_clk);
		compare_value("o_swb_stall", 32'(o_swb_stall), 32'd0);
		i_swb_cyc <= 1'b0;
		i_swb_stb <= 1'b0;
		i_swb_we <= 1'b0;
		do
			@(posedge i_clk);
		while (!o_swb_ack);
	endtask

	task automatic wb_read(input logic [1:0] addr, output logic [31:0] data);
		@(posedge i_clk);
		i_swb_cyc <= 1'b1;
		i_swb_stb <= 1'b1;
		i_swb_we <= 1'b0;
		i_swb_addr <= addr;
		@(posedge i_clk);
		compare_value("o_swb_stall", 32'(o_swb_stall), 32'd0);
		i_swb_cyc <= 1'b0;
		i_swb_stb <= 1'b0;
		do
			@(posedge i_clk);
		while (!o_swb_ack);
		data = o_swb_data;
	endtask

	// the slave fills its memory on the edge after the request
	task automatic fill_memory(input logic [31:0] key);
		@(posedge i_clk);
		fill_key <= key;
		fill_req <= 1'b1;
		@(posedge i_clk);
		fill_req <= 1'b0;
		for (int i = 0; i < 256; i++)
			ref_mem[8'(i)] = pattern_word(8'(i), key);
	endtask

	task automatic wait_interrupt();
		do
			@(posedge i_clk);
		while (!o_interrupt);
	endtask

	task automatic check_memory();
		for (int i = 0; i < 256; i++)
			compare_value($sformatf("mem[%0d]", i), mem[8'(i)], ref_mem[8'(i)]);
	endtask

	// program one transfer, update the model and check the result
	task automatic run_copy(input int len, input int src, input int dst,
		input logic [9:0] blk, input logic inc_s_n, input logic inc_d_n);
		logic [31:0] snap [0:255];
		logic [31:0] rdata;
		logic [31:0] key;
		int irq_base;
		int s;
		int d;
		int blk_words;
		int last_words;
		key = $random(seed);
		fill_memory(key);
		snap = ref_mem;
		// word i goes from src+i to dst+i, a fixed side keeps its address
		// and on a fixed destination the last word written stays
		for (int i = 0; i < len; i++)
		begin
			s = inc_s_n ? src : src + i;
			d = inc_d_n ? dst : dst + i;
			ref_mem[8'(d)] = snap[8'(s)];
		end
		// a block length of zero stands for the full buffer of 1024 words
		// and the reader's word count shows the size of the final block
		blk_words = (blk == 10'd0) ? 1024 : int'(blk);
		last_words = len - blk_words * ((len - 1) / blk_words);
		wb_write(`DMA_REG_LEN, len);
		wb_write(`DMA_REG_SRC, src * 4);
		wb_write(`DMA_REG_DST, dst * 4);
		irq_base = irq_count;
		wb_write(`DMA_REG_CTRL, ctrl_word(inc_s_n, inc_d_n, blk));
		wait_interrupt();
		wb_read(`DMA_REG_LEN, rdata);
		compare_value("len after copy", rdata, 32'd0);
		wb_read(`DMA_REG_CTRL, rdata);
		compare_value("ctrl after copy", rdata, {2'b00, inc_s_n, inc_d_n, 1'b0,
			11'(last_words), 6'd0, 10'(blk - 10'd1)});
		compare_value("interrupt count", irq_count - irq_base, 32'd1);
		check_memory();
	endtask

	////////////////////////////////////////////////////////////
	// memory slave on the master port
	////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin : bus_slave
		logic [7:0] idx;
		logic bad;
		int due;
		i_mwb_ack <= 1'b0;
		i_mwb_err <= 1'b0;
		if (fill_req)
		begin
			for (int i = 0; i < 256; i++)
				mem[8'(i)] = pattern_word(8'(i), fill_key);
		end
		if (i_reset || !o_mwb_cyc)
		begin
			// a dropped cycle cancels whatever was still owed
			q_due.delete();
			q_data.delete();
			q_err.delete();
			last_due = 0;
		end
		else
		begin
			if (o_mwb_stb && !i_mwb_stall)
			begin
				idx = o_mwb_addr[7:0];
				bad = err_en && (o_mwb_addr == err_addr);
				if (o_mwb_we && !bad)
					mem[idx] = o_mwb_data;
				// ack 1 to 3 cycles later, never ahead of an older request
				due = cycle + (($random(bus_seed) & 32'h7fff_ffff) % 3);
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				q_due.push_back(due);
				q_data.push_back(mem[idx]);
				q_err.push_back(bad);
			end
			if ((q_due.size() > 0) && (q_due[0] <= cycle))
			begin
				i_mwb_ack <= !q_err[0];
				i_mwb_err <= q_err[0];
				i_mwb_data <= q_data[0];
				void'(q_due.pop_front());
				void'(q_data.pop_front());
				void'(q_err.pop_front());
			end
		end
		// stall roughly one cycle in four
		i_mwb_stall <= (($random(bus_seed) & 3) == 0);
	end

	always @(posedge i_clk)
	begin
		if (i_reset)
			irq_count <= 0;
		else if (o_interrupt)
			irq_count <= irq_count + 1;
	end

	always @(posedge i_clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES)
			report_failure($sformatf("timeout: run did not finish in %0d cycles", MAX_CYCLES));
	end

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0] rdata;
		logic [31:0] t_len;
		logic [31:0] t_src;
		logic [31:0] t_dst;
		int len;
		int src;
		int dst;
		int irq_base;
		i_reset <= 1'b1;
		i_swb_cyc <= 1'b0;
		i_swb_stb <= 1'b0;
		i_swb_we <= 1'b0;
		i_swb_addr <= 2'd0;
		i_swb_data <= 32'd0;
		repeat (2) @(posedge i_clk);
		i_reset <= 1'b0;
		@(posedge i_clk);
		compare_value("o_interrupt", 32'(o_interrupt), 32'd0);
		compare_value("o_swb_ack", 32'(o_swb_ack), 32'd0);
		compare_value("o_mwb_cyc", 32'(o_mwb_cyc), 32'd0);
		compare_value("o_mwb_stb", 32'(o_mwb_stb), 32'd0);
		wb_read(`DMA_REG_CTRL, rdata);
		compare_value("ctrl busy", 32'(rdata[31]), 32'd0);

		// registers written while idle read back as written
		t_len = $random(seed) & 32'h3fff_ffff;
		t_src = $random(seed) & 32'hffff_fffc;
		t_dst = $random(seed) & 32'hffff_fffc;
		wb_write(`DMA_REG_LEN, t_len);
		wb_write(`DMA_REG_SRC, t_src);
		wb_write(`DMA_REG_DST, t_dst);
		wb_read(`DMA_REG_LEN, rdata);
		compare_value("len", rdata, t_len);
		wb_read(`DMA_REG_SRC, rdata);
		compare_value("src", rdata, t_src);
		wb_read(`DMA_REG_DST, rdata);
		compare_value("dst", rdata, t_dst);

		// single block copies, source in the low quarter and destination above it
		repeat (6)
			run_copy(1 + random_below(40), random_below(64), 128 + random_below(64),
				10'd0, 1'b0, 1'b0);

		// 13 words in blocks of 4
		src = random_below(64);
		dst = 128 + random_below(64);
		run_copy(13, src, dst, 10'd4, 1'b0, 1'b0);
		wb_read(`DMA_REG_SRC, rdata);
		compare_value("src after blocks", rdata, (src + 13) * 4);
		wb_read(`DMA_REG_DST, rdata);
		compare_value("dst after blocks", rdata, (dst + 13) * 4);

		// fixed source, then fixed destination
		run_copy(1 + random_below(40), random_below(64), 128 + random_below(64),
			10'd0, 1'b1, 1'b0);
		run_copy(1 + random_below(40), random_below(64), 128 + random_below(64),
			10'd0, 1'b0, 1'b1);
		run_copy(10, random_below(64), 128 + random_below(64), 10'd4, 1'b0, 1'b1);

		// bus error, first on a read and then on a write
		for (int k = 0; k < 2; k++)
		begin
			len = 20;
			src = random_below(64);
			dst = 128 + random_below(64);
			fill_memory($random(seed));
			@(posedge i_clk);
			err_addr <= (k == 0) ? 30'(src + 5) : 30'(dst + 7);
			err_en <= 1'b1;
			wb_write(`DMA_REG_LEN, len);
			wb_write(`DMA_REG_SRC, src * 4);
			wb_write(`DMA_REG_DST, dst * 4);
			irq_base = irq_count;
			wb_write(`DMA_REG_CTRL, ctrl_word(1'b0, 1'b0, 10'd0));
			wait_interrupt();
			wb_read(`DMA_REG_CTRL, rdata);
			compare_value("ctrl err after bus error", 32'(rdata[30]), 32'd1);
			compare_value("ctrl busy after bus error", 32'(rdata[31]), 32'd0);
			compare_value("interrupt count after bus error", irq_count - irq_base, 32'd1);
			err_en <= 1'b0;
			// a control write without the key only clears the error
			wb_write(`DMA_REG_CTRL, 32'd0);
			wb_read(`DMA_REG_CTRL, rdata);
			compare_value("ctrl err after clear", 32'(rdata[30]), 32'd0);
		end

		// long transfer that is stopped while it reads
		fill_memory($random(seed));
		wb_write(`DMA_REG_LEN, 32'd1000);
		wb_write(`DMA_REG_SRC, 32'd0);
		wb_write(`DMA_REG_DST, 32'd512);
		wb_write(`DMA_REG_CTRL, ctrl_word(1'b0, 1'b0, 10'd0));
		repeat (20) @(posedge i_clk);
		wb_write(`DMA_REG_LEN, 32'd5);
		wb_read(`DMA_REG_LEN, rdata);
		compare_value("len written while busy", rdata, 32'd1000);
		wb_read(`DMA_REG_CTRL, rdata);
		compare_value("ctrl busy during copy", 32'(rdata[31]), 32'd1);
		wb_write(`DMA_REG_CTRL, `DMA_ABORT_WORD);
		// the abort write was taken two edges before this sample
		@(posedge i_clk);
		if (o_mwb_cyc)
			report_failure("master cycle still open two cycles after the abort write");
		wb_read(`DMA_REG_CTRL, rdata);
		compare_value("ctrl busy after abort", 32'(rdata[31]), 32'd0);
		compare_value("ctrl err after abort", 32'(rdata[30]), 32'd1);

		$display("PASS: all tests");
		$finish;
	end

endmodule

/* wb_dma.sv */
// Wishbone block copy DMA
`timescale 1ns/1ps
`include "dma_params.svh"

module wb_dma (
	input logic i_clk,
	input logic i_reset,
	input logic i_swb_cyc,
	input logic i_swb_stb,
	input logic i_swb_we,
	input logic [1:0] i_swb_addr,
	input logic [`DMA_DW-1:0] i_swb_data,
	output logic o_swb_ack,
	output logic o_swb_stall,
	output logic [`DMA_DW-1:0] o_swb_data,
	output logic o_mwb_cyc,
	output logic o_mwb_stb,
	output logic o_mwb_we,
	output logic [`DMA_AW-1:0] o_mwb_addr,
	output logic [`DMA_DW-1:0] o_mwb_data,
	input logic i_mwb_ack,
	input logic i_mwb_stall,
	input logic i_mwb_err,
	input logic [`DMA_DW-1:0] i_mwb_data,
	output logic o_interrupt
);
	import dma_pkg::*;

	localparam int LGBLK = `DMA_LGBLK;

	dma_job_t rd_job;
	dma_job_t wr_job;
	logic rd_start;
	logic wr_start;
	logic abort;
	logic rd_done;
	logic rd_err;
	logic rd_busy;
	logic [LGBLK:0] rd_nread;
	logic wr_done;
	logic wr_err;

	wb_req_t rd_req;
	wb_req_t wr_req;
	wb_req_t m_req;
	wb_rsp_t m_rsp;

	logic buf_we;
	logic [LGBLK-1:0] buf_widx;
	logic [`DMA_DW-1:0] buf_wdata;
	logic [LGBLK-1:0] buf_ridx;
	logic [`DMA_DW-1:0] buf_rdata;

	// the slave port answers every access on the next cycle
	assign o_swb_stall = 1'b0;

	dma_ctrl u_ctrl (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_swb_stb(i_swb_stb),
		.i_swb_cyc(i_swb_cyc),
		.i_swb_we(i_swb_we),
		.i_swb_addr(i_swb_addr),
		.i_swb_data(i_swb_data),
		.i_rd_done(rd_done),
		.i_rd_err(rd_err),
		.i_rd_nread(rd_nread),
		.i_wr_done(wr_done),
		.i_wr_err(wr_err),
		.o_swb_ack(o_swb_ack),
		.o_swb_data(o_swb_data),
		.o_rd_start(rd_start),
		.o_rd_job(rd_job),
		.o_wr_start(wr_start),
		.o_wr_job(wr_job),
		.o_abort(abort),
		.o_interrupt(o_interrupt)
	);

	dma_block_reader u_reader (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_start(rd_start),
		.i_job(rd_job),
		.i_abort(abort),
		.i_rsp(m_rsp),
		.o_req(rd_req),
		.o_buf_we(buf_we),
		.o_buf_idx(buf_widx),
		.o_buf_data(buf_wdata),
		.o_nread(rd_nread),
		.o_busy(rd_busy),
		.o_done(rd_done),
		.o_err(rd_err)
	);

	dma_block_buf u_buf (
		.i_clk(i_clk),
		.i_we(buf_we),
		.i_widx(buf_widx),
		.i_wdata(buf_wdata),
		.i_ridx(buf_ridx),
		.o_rdata(buf_rdata)
	);

	dma_block_writer u_writer (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_start(wr_start),
		.i_job(wr_job),
		.i_abort(abort),
		.i_rsp(m_rsp),
		.i_buf_data(buf_rdata),
		.o_req(wr_req),
		.o_buf_idx(buf_ridx),
		.o_done(wr_done),
		.o_err(wr_err)
	);

	////////////////////////////////////////////////////////////
	// master bus
	////////////////////////////////////////////////////////////

	// both engines see every response and only the one with cyc up acts on it
	assign m_rsp = '{ack: i_mwb_ack, stall: i_mwb_stall, err: i_mwb_err, data: i_mwb_data};

	// the phases never overlap, and the idle writer drives an empty request
	assign m_req = rd_busy ? rd_req : wr_req;

	assign o_mwb_cyc = m_req.cyc;
	assign o_mwb_stb = m_req.stb;
	assign o_mwb_we = m_req.we;
	assign o_mwb_addr = m_req.addr;
	assign o_mwb_data = m_req.data;

endmodule

/* dma_block_writer.sv */
// DMA block writer
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_block_writer (
	input logic i_clk,
	input logic i_reset,
	input logic i_start,
	input dma_pkg::dma_job_t i_job,
	input logic i_abort,
	input dma_pkg::wb_rsp_t i_rsp,
	input logic [`DMA_DW-1:0] i_buf_data,
	output dma_pkg::wb_req_t o_req,
	output logic [`DMA_LGBLK-1:0] o_buf_idx,
	output logic o_done,
	output logic o_err
);
	localparam int AW = `DMA_AW;
	localparam int LGBLK = `DMA_LGBLK;

	logic r_cyc;
	logic r_stb;
	logic r_pre;
	logic [AW-1:0] r_addr;
	logic [LGBLK:0] r_nreq;
	logic [LGBLK:0] r_nack;
	logic [LGBLK:0] r_count;
	logic r_inc;

	logic accept;
	logic last_ack;
	logic [LGBLK:0] nreq_next;

	assign accept = r_stb && !i_rsp.stall;
	assign last_ack = r_cyc && i_rsp.ack && ((r_nack + 1'b1) == r_count);
	assign nreq_next = r_nreq + {{LGBLK{1'b0}}, accept};

	assign o_err = r_cyc && (i_rsp.err || i_abort);
	assign o_done = last_ack && !o_err;

	// the word on the bus was read from the index of the cycle before
	// the index only moves past a request once that request is taken,
	// so a stalled request keeps its data
	assign o_buf_idx = nreq_next[LGBLK-1:0];

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
			r_pre <= 1'b0;
			r_nreq <= '0;
			r_nack <= '0;
		end
		else if (i_start)
		begin
			// the first cycle only fetches word 0 from the buffer
			r_cyc <= 1'b1;
			r_stb <= 1'b0;
			r_pre <= 1'b1;
			r_addr <= i_job.addr;
			r_count <= i_job.count;
			r_inc <= i_job.inc;
			r_nreq <= '0;
			r_nack <= '0;
		end
		else if (o_err)
		begin
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
			r_pre <= 1'b0;
		end
		else if (r_cyc)
		begin
			if (r_pre)
			begin
				r_pre <= 1'b0;
				r_stb <= 1'b1;
			end
			if (accept)
			begin
				r_addr <= r_addr + {{(AW-1){1'b0}}, r_inc};
				if (nreq_next == r_count)
					r_stb <= 1'b0;
			end
			r_nreq <= nreq_next;
			if (i_rsp.ack)
				r_nack <= r_nack + 1'b1;
			if (last_ack)
				r_cyc <= 1'b0;
		end
	end

	assign o_req = '{cyc: r_cyc, stb: r_stb, we: 1'b1, addr: r_addr, data: i_buf_data};

endmodule

/* dma_block_buf.sv */
// DMA block buffer
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_block_buf (
	input logic i_clk,
	input logic i_we,
	input logic [`DMA_LGBLK-1:0] i_widx,
	input logic [`DMA_DW-1:0] i_wdata,
	input logic [`DMA_LGBLK-1:0] i_ridx,
	output logic [`DMA_DW-1:0] o_rdata
);
	localparam int DEPTH = 1 << `DMA_LGBLK;

	// one block of words, filled by the reader and drained by the writer
	logic [`DMA_DW-1:0] mem [0:DEPTH-1];

	// write port, written from the read acks
	always_ff @(posedge i_clk)
	begin
		if (i_we)
			mem[i_widx] <= i_wdata;
	end

	// read port with a registered output, so the word follows its index
	// by one cycle and the array maps onto a block RAM
	always_ff @(posedge i_clk)
	begin
		o_rdata <= mem[i_ridx];
	end

endmodule

/* dma_block_reader.sv */
// DMA block reader
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_block_reader (
	input logic i_clk,
	input logic i_reset,
	input logic i_start,
	input dma_pkg::dma_job_t i_job,
	input logic i_abort,
	input dma_pkg::wb_rsp_t i_rsp,
	output dma_pkg::wb_req_t o_req,
	output logic o_buf_we,
	output logic [`DMA_LGBLK-1:0] o_buf_idx,
	output logic [`DMA_DW-1:0] o_buf_data,
	output logic [`DMA_LGBLK:0] o_nread,
	output logic o_busy,
	output logic o_done,
	output logic o_err
);
	localparam int AW = `DMA_AW;
	localparam int LGBLK = `DMA_LGBLK;

	logic r_cyc;
	logic r_stb;
	logic [AW-1:0] r_addr;
	logic [LGBLK:0] r_nreq;
	logic [LGBLK:0] r_nack;
	logic [LGBLK:0] r_count;
	logic r_inc;

	logic accept;
	logic last_ack;

	assign accept = r_stb && !i_rsp.stall;
	assign last_ack = r_cyc && i_rsp.ack && ((r_nack + 1'b1) == r_count);

	// both flags are combinational so the sequencer sees them with the ack
	assign o_err = r_cyc && (i_rsp.err || i_abort);
	assign o_done = last_ack && !o_err;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
			r_nreq <= '0;
			r_nack <= '0;
		end
		else if (i_start)
		begin
			r_cyc <= 1'b1;
			r_stb <= 1'b1;
			r_addr <= i_job.addr;
			r_count <= i_job.count;
			r_inc <= i_job.inc;
			r_nreq <= '0;
			r_nack <= '0;
		end
		else if (o_err)
		begin
			// a bus error or an abort ends the cycle at once
			r_cyc <= 1'b0;
			r_stb <= 1'b0;
		end
		else if (r_cyc)
		begin
			// requests run ahead of the acks, so several reads are in flight
			if (accept)
			begin
				r_nreq <= r_nreq + 1'b1;
				r_addr <= r_addr + {{(AW-1){1'b0}}, r_inc};
				if ((r_nreq + 1'b1) == r_count)
					r_stb <= 1'b0;
			end
			if (i_rsp.ack)
				r_nack <= r_nack + 1'b1;
			if (last_ack)
				r_cyc <= 1'b0;
		end
	end

	assign o_req = '{cyc: r_cyc, stb: r_stb, we: 1'b0, addr: r_addr, data: '0};

	// acks come back in order, so the ack count is the buffer slot
	assign o_buf_we = r_cyc && i_rsp.ack;
	assign o_buf_idx = r_nack[LGBLK-1:0];
	assign o_buf_data = i_rsp.data;

	assign o_nread = r_nack;
	assign o_busy = r_cyc;

endmodule

/* dma_ctrl.sv */
// DMA registers and sequencer
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_ctrl (
	input logic i_clk,
	input logic i_reset,
	input logic i_swb_stb,
	input logic i_swb_cyc,
	input logic i_swb_we,
	input logic [1:0] i_swb_addr,
	input logic [`DMA_DW-1:0] i_swb_data,
	input logic i_rd_done,
	input logic i_rd_err,
	input logic [`DMA_LGBLK:0] i_rd_nread,
	input logic i_wr_done,
	input logic i_wr_err,
	output logic o_swb_ack,
	output logic [`DMA_DW-1:0] o_swb_data,
	output logic o_rd_start,
	output dma_pkg::dma_job_t o_rd_job,
	output logic o_wr_start,
	output dma_pkg::dma_job_t o_wr_job,
	output logic o_abort,
	output logic o_interrupt
);
	import dma_pkg::*;

	localparam int AW = `DMA_AW;
	localparam int DW = `DMA_DW;
	localparam int LGBLK = `DMA_LGBLK;

	// sequencer states, each start state lasts exactly one cycle
	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_START = 3'd1;
	localparam logic [2:0] S_READ = 3'd2;
	localparam logic [2:0] S_WSTART = 3'd3;
	localparam logic [2:0] S_WRITE = 3'd4;
	localparam logic [2:0] S_ABORT = 3'd5;

	logic [2:0] state;
	logic busy;

	// programmed transfer, addresses are kept as word addresses
	logic [AW-1:0] cfg_len;
	logic [AW-1:0] cfg_src;
	logic [AW-1:0] cfg_dst;
	logic [LGBLK-1:0] cfg_blklen_m1;
	logic cfg_inc_s_n;
	logic cfg_inc_d_n;
	logic cfg_err;

	logic wr_sel;
	logic is_abort;
	dma_ctrl_word_u wr_word;
	dma_ctrl_word_u rd_word;

	// block sizing
	logic [LGBLK:0] blk_full;
	logic [AW-1:0] full_ext;
	logic [LGBLK:0] blk_cnt;
	logic [AW-1:0] cnt_ext;

	assign busy = (state != S_IDLE);

	// a slave write is taken in the same cycle as it is presented
	assign wr_sel = i_swb_stb && i_swb_cyc && i_swb_we;
	assign wr_word = i_swb_data;
	assign is_abort = wr_sel && (i_swb_addr == `DMA_REG_CTRL)
		&& (i_swb_data == `DMA_ABORT_WORD);

	// a block length field of zero wraps to all ones, i.e. the whole buffer
	assign blk_full = {1'b0, cfg_blklen_m1} + 1'b1;
	assign full_ext = {{(AW-LGBLK-1){1'b0}}, blk_full};

	// the final block of a transfer may be shorter than the block length
	assign blk_cnt = (cfg_len < full_ext) ? cfg_len[LGBLK:0] : blk_full;
	assign cnt_ext = {{(AW-LGBLK-1){1'b0}}, blk_cnt};

	// jobs follow the registers, which only move at the end of a block
	assign o_rd_job = '{addr: cfg_src, count: blk_cnt, inc: !cfg_inc_s_n};
	assign o_wr_job = '{addr: cfg_dst, count: blk_cnt, inc: !cfg_inc_d_n};

	assign o_rd_start = (state == S_START);
	assign o_wr_start = (state == S_WSTART);

	// held for one cycle, long enough for either engine to drop its cycle
	assign o_abort = (state == S_ABORT);

	////////////////////////////////////////////////////////////
	// register writes and transfer sequencing
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= S_IDLE;
			o_interrupt <= 1'b0;
			cfg_err <= 1'b0;
			cfg_len <= '0;
			cfg_blklen_m1 <= '1;
			cfg_inc_s_n <= 1'b0;
			cfg_inc_d_n <= 1'b0;
		end
		else
		begin
			o_interrupt <= 1'b0;
			case (state)
			S_IDLE:
			begin
				// the abort word means nothing while idle and is dropped
				if (wr_sel && !is_abort)
				begin
					case (i_swb_addr)
					`DMA_REG_CTRL:
					begin
						cfg_blklen_m1 <= wr_word.cmd.blklen - 1'b1;
						cfg_inc_s_n <= wr_word.cmd.inc_s_n;
						cfg_inc_d_n <= wr_word.cmd.inc_d_n;
						cfg_err <= 1'b0;
						// a zero length never starts, the key alone is not enough
						if ((wr_word.cmd.key == `DMA_UNLOCK_KEY)
							&& (wr_word.cmd.stat == 2'b00) && (cfg_len != '0))
							state <= S_START;
					end
					`DMA_REG_LEN:
						cfg_len <= i_swb_data[AW-1:0];
					`DMA_REG_SRC:
						cfg_src <= i_swb_data[DW-1:2];
					default:
						cfg_dst <= i_swb_data[DW-1:2];
					endcase
				end
			end
			S_START:
				state <= S_READ;
			S_READ:
			begin
				if (i_rd_err)
				begin
					cfg_err <= 1'b1;
					o_interrupt <= 1'b1;
					state <= S_IDLE;
				end
				else if (i_rd_done)
					state <= S_WSTART;
			end
			S_WSTART:
				state <= S_WRITE;
			S_WRITE:
			begin
				if (i_wr_err)
				begin
					cfg_err <= 1'b1;
					o_interrupt <= 1'b1;
					state <= S_IDLE;
				end
				else if (i_wr_done)
				begin
					// retire the block and move on past it
					cfg_len <= cfg_len - cnt_ext;
					if (!cfg_inc_s_n)
						cfg_src <= cfg_src + cnt_ext;
					if (!cfg_inc_d_n)
						cfg_dst <= cfg_dst + cnt_ext;
					if (cfg_len == cnt_ext)
					begin
						o_interrupt <= 1'b1;
						state <= S_IDLE;
					end
					else
						state <= S_START;
				end
			end
			S_ABORT:
				state <= S_IDLE;
			default:
				state <= S_IDLE;
			endcase

			// an abort overrides whatever the sequencer chose this cycle
			if (busy && is_abort && (state != S_ABORT))
			begin
				cfg_err <= 1'b1;
				state <= S_ABORT;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// register reads
	////////////////////////////////////////////////////////////

	always_comb
	begin
		rd_word = '0;
		rd_word.stat.busy = busy;
		rd_word.stat.err = cfg_err;
		rd_word.stat.inc_s_n = cfg_inc_s_n;
		rd_word.stat.inc_d_n = cfg_inc_d_n;
		rd_word.stat.nread = i_rd_nread;
		rd_word.stat.blklen_m1 = cfg_blklen_m1;
	end

	// read data is registered and lines up with the ack
	always_ff @(posedge i_clk)
	begin
		case (i_swb_addr)
		`DMA_REG_CTRL:
			o_swb_data <= rd_word;
		`DMA_REG_LEN:
			o_swb_data <= {{(DW-AW){1'b0}}, cfg_len};
		`DMA_REG_SRC:
			o_swb_data <= {cfg_src, 2'b00};
		default:
			o_swb_data <= {cfg_dst, 2'b00};
		endcase
	end

	// every access is acked, even a write that was ignored
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_swb_ack <= 1'b0;
		else
			o_swb_ack <= i_swb_stb && i_swb_cyc;
	end

endmodule

/* dma_pkg.sv */
// DMA shared types
`include "dma_params.svh"

package dma_pkg;

	// request from one engine towards the master bus
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`DMA_AW-1:0] addr;
		logic [`DMA_DW-1:0] data;
	} wb_req_t;

	// what the addressed slave returns to the master
	typedef struct packed {
		logic ack;
		logic stall;
		logic err;
		logic [`DMA_DW-1:0] data;
	} wb_rsp_t;

	// one block of work handed to the reader or the writer
	typedef struct packed {
		logic [`DMA_AW-1:0] addr;
		logic [`DMA_LGBLK:0] count;
		logic inc;
	} dma_job_t;

	// control word as the host writes it
	// the two status bits at the top are read only and must be zero to start
	typedef struct packed {
		logic [1:0] stat;
		logic inc_s_n;
		logic inc_d_n;
		logic [11:0] key;
		logic [15-`DMA_LGBLK:0] zero;
		logic [`DMA_LGBLK-1:0] blklen;
	} dma_cmd_t;

	// control word as the host reads it back
	typedef struct packed {
		logic busy;
		logic err;
		logic inc_s_n;
		logic inc_d_n;
		logic zero;
		logic [`DMA_LGBLK:0] nread;
		logic [15-`DMA_LGBLK:0] rsvd;
		logic [`DMA_LGBLK-1:0] blklen_m1;
	} dma_stat_t;

	// one 32-bit register word seen through either view
	typedef union packed {
		dma_cmd_t cmd;
		dma_stat_t stat;
	} dma_ctrl_word_u;

endpackage

/* dma_params.svh */
// DMA engine constants
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// word address width of the master bus, so a byte address is two bits wider
`define DMA_AW 30

// data width of both the slave and the master bus
`define DMA_DW 32

// log2 of the block buffer depth in words
// the control word layout assumes this stays at 10
`define DMA_LGBLK 10

// slave register map, one 32-bit word per register
`define DMA_REG_CTRL 2'd0
`define DMA_REG_LEN 2'd1
`define DMA_REG_SRC 2'd2
`define DMA_REG_DST 2'd3

// key in bits 27..16 of a control write that starts a transfer
`define DMA_UNLOCK_KEY 12'hfed

// full control word that stops a running transfer
`define DMA_ABORT_WORD 32'hffed0000

`endif
